/* common/rv_isa_pkg.sv */
package rv_isa_pkg;

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [6:0]  opcode_t;

  localparam opcode_t op_lui    = 7'b0110111;
  localparam opcode_t op_imm    = 7'b0010011;
  localparam opcode_t op_reg    = 7'b0110011;
  localparam opcode_t op_load   = 7'b0000011;
  localparam opcode_t op_store  = 7'b0100011;

  // register-register and immediate ops, then the M extension
  typedef enum logic [4:0] {
    alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor, alu_srl, alu_sra,
    alu_or, alu_and, alu_lui_pass,
    alu_mul, alu_mulh, alu_mulhu, alu_mulhsu, alu_div, alu_divu, alu_rem, alu_remu
  } alu_op_t;

  typedef enum logic [3:0] {
    mem_none, mem_lb, mem_lbu, mem_lh, mem_lhu, mem_lw, mem_sb, mem_sh, mem_sw
  } mem_op_t;

endpackage

/* common/pipe_pkg.sv */
package pipe_pkg;

  // decoder to executor
  typedef struct packed {
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::word_t     a;
    rv_isa_pkg::word_t     b;
    rv_isa_pkg::word_t     store_data;
    rv_isa_pkg::alu_op_t   alu_op;
    rv_isa_pkg::mem_op_t   mem_op;
  } decoded_t;

  // executor to accessor, result holds the address for loads and stores
  typedef struct packed {
    rv_isa_pkg::reg_addr_t rd;
    rv_isa_pkg::word_t     result;
    rv_isa_pkg::word_t     store_data;
    rv_isa_pkg::mem_op_t   mem_op;
  } executed_t;

endpackage

/* hdl/register_file.sv */
`timescale 1ns/1ns

module register_file (
  input  var logic                  clk,
  input  var logic                  reset,
  input  var rv_isa_pkg::reg_addr_t rs1_addr,
  input  var rv_isa_pkg::reg_addr_t rs2_addr,
  output var rv_isa_pkg::word_t     rs1_data,
  output var rv_isa_pkg::word_t     rs2_data,
  input  var logic                  wb_en,
  input  var rv_isa_pkg::reg_addr_t wb_rd,
  input  var rv_isa_pkg::word_t     wb_data
);
  rv_isa_pkg::word_t regs [1:31];

  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

  always_ff @(posedge clk) begin
    if (wb_en && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  // retires aimed at x0 are stores or dropped writes and carry no data
  a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
    wb_en && wb_rd == '0 |-> wb_data == '0)
    else $error("register_file: data written towards x0");

endmodule

/* decoder/decoder.sv */
`timescale 1ns/1ns

module decoder (
  input  var logic                  clk,
  input  var logic                  reset,
  input  var logic                  instr_valid,
  input  var rv_isa_pkg::word_t     instr,
  output var logic                  instr_ready,
  output var rv_isa_pkg::reg_addr_t rs1_addr,
  output var rv_isa_pkg::reg_addr_t rs2_addr,
  input  var rv_isa_pkg::word_t     rs1_data,
  input  var rv_isa_pkg::word_t     rs2_data,
  output var logic                  dec_valid,
  output var pipe_pkg::decoded_t    dec,
  input  var logic                  dec_ready,
  input  var logic                  wb_en,
  input  var rv_isa_pkg::reg_addr_t wb_rd
);
  rv_isa_pkg::opcode_t opcode;
  logic [2:0]          funct3;
  rv_isa_pkg::word_t   imm_i, imm_s, imm_u;
  pipe_pkg::decoded_t  next_dec;
  logic                uses_rs1, uses_rs2, src_busy, accept;
  logic [31:0]         busy;

  function automatic rv_isa_pkg::alu_op_t alu_from_funct3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? rv_isa_pkg::alu_sub : rv_isa_pkg::alu_add;
      3'b001:  return rv_isa_pkg::alu_sll;
      3'b010:  return rv_isa_pkg::alu_slt;
      3'b011:  return rv_isa_pkg::alu_sltu;
      3'b100:  return rv_isa_pkg::alu_xor;
      3'b101:  return alt ? rv_isa_pkg::alu_sra : rv_isa_pkg::alu_srl;
      3'b110:  return rv_isa_pkg::alu_or;
      default: return rv_isa_pkg::alu_and;
    endcase
  endfunction

  assign opcode   = instr[6:0];
  assign funct3   = instr[14:12];
  assign rs1_addr = instr[19:15];
  assign rs2_addr = instr[24:20];
  assign imm_i    = {{20{instr[31]}}, instr[31:20]};
  assign imm_s    = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_u    = {instr[31:12], 12'b0};

  always_comb begin
    // unknown encodings fall through as a no-op with rd 0
    next_dec = '{rd: '0, a: '0, b: '0, store_data: '0,
                 alu_op: rv_isa_pkg::alu_add, mem_op: rv_isa_pkg::mem_none};
    uses_rs1 = 1'b0;
    uses_rs2 = 1'b0;
    case (opcode)
      rv_isa_pkg::op_lui: begin
        next_dec.rd     = instr[11:7];
        next_dec.b      = imm_u;
        next_dec.alu_op = rv_isa_pkg::alu_lui_pass;
      end
      rv_isa_pkg::op_imm: begin
        uses_rs1        = 1'b1;
        next_dec.rd     = instr[11:7];
        next_dec.a      = rs1_data;
        next_dec.b      = imm_i;
        next_dec.alu_op = alu_from_funct3(funct3, funct3 == 3'b101 && instr[30]);
      end
      rv_isa_pkg::op_reg: begin
        uses_rs1    = 1'b1;
        uses_rs2    = 1'b1;
        next_dec.rd = instr[11:7];
        next_dec.a  = rs1_data;
        next_dec.b  = rs2_data;
        if (instr[25]) begin
          case (funct3)
            3'b000:  next_dec.alu_op = rv_isa_pkg::alu_mul;
            3'b001:  next_dec.alu_op = rv_isa_pkg::alu_mulh;
            3'b010:  next_dec.alu_op = rv_isa_pkg::alu_mulhsu;
            3'b011:  next_dec.alu_op = rv_isa_pkg::alu_mulhu;
            3'b100:  next_dec.alu_op = rv_isa_pkg::alu_div;
            3'b101:  next_dec.alu_op = rv_isa_pkg::alu_divu;
            3'b110:  next_dec.alu_op = rv_isa_pkg::alu_rem;
            default: next_dec.alu_op = rv_isa_pkg::alu_remu;
          endcase
        end else begin
          next_dec.alu_op = alu_from_funct3(funct3, instr[30]);
        end
      end
      rv_isa_pkg::op_load: begin
        uses_rs1   = 1'b1;
        next_dec.a = rs1_data;
        next_dec.b = imm_i;
        case (funct3)
          3'b000:  next_dec.mem_op = rv_isa_pkg::mem_lb;
          3'b001:  next_dec.mem_op = rv_isa_pkg::mem_lh;
          3'b010:  next_dec.mem_op = rv_isa_pkg::mem_lw;
          3'b100:  next_dec.mem_op = rv_isa_pkg::mem_lbu;
          3'b101:  next_dec.mem_op = rv_isa_pkg::mem_lhu;
          default: next_dec.mem_op = rv_isa_pkg::mem_none;
        endcase
        if (next_dec.mem_op != rv_isa_pkg::mem_none) begin
          next_dec.rd = instr[11:7];
        end
      end
      rv_isa_pkg::op_store: begin
        uses_rs1            = 1'b1;
        uses_rs2            = 1'b1;
        next_dec.a          = rs1_data;
        next_dec.b          = imm_s;
        next_dec.store_data = rs2_data;
        case (funct3)
          3'b000:  next_dec.mem_op = rv_isa_pkg::mem_sb;
          3'b001:  next_dec.mem_op = rv_isa_pkg::mem_sh;
          3'b010:  next_dec.mem_op = rv_isa_pkg::mem_sw;
          default: next_dec.mem_op = rv_isa_pkg::mem_none;
        endcase
      end
      default: ;
    endcase
  end

  assign src_busy    = (uses_rs1 && busy[rs1_addr]) || (uses_rs2 && busy[rs2_addr]);
  assign instr_ready = !reset && (!dec_valid || dec_ready) && !src_busy;
  assign accept      = instr_valid && instr_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      dec_valid <= 1'b0;
      busy      <= '0;
    end else begin
      if (accept) begin
        dec_valid <= 1'b1;
      end else if (dec_ready) begin
        dec_valid <= 1'b0;
      end
      if (wb_en) begin
        busy[wb_rd] <= 1'b0;
      end
      // set after the clear so a reissued rd stays busy
      if (accept && next_dec.rd != '0) begin
        busy[next_dec.rd] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      dec <= next_dec;
    end
  end

  a_dec_stable: assert property (@(posedge clk) disable iff (reset)
    dec_valid && !dec_ready |=> dec_valid && $stable(dec))
    else $error("decoder: output changed while stalled");

endmodule

/* executor/mul_div_unit.sv */
`timescale 1ns/1ns

module mul_div_unit (
  input  var logic                clk,
  input  var logic                reset,
  input  var logic                start,
  input  var rv_isa_pkg::alu_op_t op,
  input  var rv_isa_pkg::word_t   a,
  input  var rv_isa_pkg::word_t   b,
  output var logic                done,
  output var rv_isa_pkg::word_t   result
);
  typedef enum logic [1:0] {st_idle, st_multiply, st_divide} state_t;

  state_t              state;
  rv_isa_pkg::alu_op_t op_q;
  logic [6:0]          count;
  logic [63:0]         reg_a, reg_b, acc, shifted;
  logic                neg_q, neg_r, div_signed, is_div;
  rv_isa_pkg::word_t   abs_a, abs_b;

  assign is_div     = op >= rv_isa_pkg::alu_div;
  assign div_signed = op == rv_isa_pkg::alu_div || op == rv_isa_pkg::alu_rem;
  assign abs_a      = (div_signed && a[31]) ? -a : a;
  assign abs_b      = (div_signed && b[31]) ? -b : b;
  // remainder gains the next dividend bit
  assign shifted    = {acc[62:0], reg_a[63]};
  assign done       = state != st_idle && count == '0;

  always_comb begin
    case (op_q)
      rv_isa_pkg::alu_mul:                      result = acc[31:0];
      rv_isa_pkg::alu_div, rv_isa_pkg::alu_divu: result = reg_a[31:0];
      rv_isa_pkg::alu_rem, rv_isa_pkg::alu_remu: result = acc[31:0];
      default:                                  result = acc[63:32];
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
    end else if (start) begin
      state <= is_div ? st_divide : st_multiply;
    end else if (done) begin
      state <= st_idle;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      op_q  <= op;
      acc   <= '0;
      neg_q <= div_signed && (a[31] ^ b[31]) && b != '0;
      neg_r <= div_signed && a[31];
      if (is_div) begin
        // 64 steps, then one for the sign fix
        count <= 7'd65;
        reg_a <= {32'b0, abs_a};
        reg_b <= {32'b0, abs_b};
      end else begin
        count <= (op == rv_isa_pkg::alu_mul) ? 7'd32 : 7'd64;
        reg_a <= (op == rv_isa_pkg::alu_mulhu) ? {32'b0, a} : {{32{a[31]}}, a};
        reg_b <= (op == rv_isa_pkg::alu_mulh) ? {{32{b[31]}}, b} : {32'b0, b};
      end
    end else if (state == st_multiply && count != '0) begin
      if (reg_b[0]) begin
        acc <= acc + reg_a;
      end
      reg_a <= reg_a << 1;
      reg_b <= reg_b >> 1;
      count <= count - 7'd1;
    end else if (state == st_divide && count > 7'd1) begin
      if (shifted >= reg_b) begin
        acc   <= shifted - reg_b;
        reg_a <= {reg_a[62:0], 1'b1};
      end else begin
        acc   <= shifted;
        reg_a <= {reg_a[62:0], 1'b0};
      end
      count <= count - 7'd1;
    end else if (state == st_divide && count == 7'd1) begin
      if (neg_q) begin
        reg_a[31:0] <= -reg_a[31:0];
      end
      if (neg_r) begin
        acc[31:0] <= -acc[31:0];
      end
      count <= '0;
    end
  end

  a_start_idle: assert property (@(posedge clk) disable iff (reset)
    start |-> state == st_idle)
    else $error("mul_div_unit: start while busy");

  a_done_pulse: assert property (@(posedge clk) disable iff (reset)
    done |=> !done)
    else $error("mul_div_unit: done held longer than one cycle");

endmodule

/* executor/executor.sv */
`timescale 1ns/1ns

module executor (
  input  var logic                clk,
  input  var logic                reset,
  input  var logic                dec_valid,
  input  var pipe_pkg::decoded_t  dec,
  output var logic                exec_ready,
  output var logic                exec_valid,
  output var pipe_pkg::executed_t exec,
  input  var logic                accessor_ready
);
  typedef enum logic [1:0] {st_idle, st_wait_mul_div, st_hold} state_t;

  state_t            state;
  rv_isa_pkg::word_t alu_result, md_result;
  logic              is_m, take, start, done;

  assign is_m       = dec.alu_op >= rv_isa_pkg::alu_mul;
  assign exec_ready = (state == st_idle) && (!exec_valid || accessor_ready);
  assign take       = dec_valid && exec_ready;
  assign start      = take && is_m;

  always_comb begin
    case (dec.alu_op)
      rv_isa_pkg::alu_add:      alu_result = dec.a + dec.b;
      rv_isa_pkg::alu_sub:      alu_result = dec.a - dec.b;
      rv_isa_pkg::alu_sll:      alu_result = dec.a << dec.b[4:0];
      rv_isa_pkg::alu_slt:      alu_result = {31'b0, $signed(dec.a) < $signed(dec.b)};
      rv_isa_pkg::alu_sltu:     alu_result = {31'b0, dec.a < dec.b};
      rv_isa_pkg::alu_xor:      alu_result = dec.a ^ dec.b;
      rv_isa_pkg::alu_srl:      alu_result = dec.a >> dec.b[4:0];
      rv_isa_pkg::alu_sra:      alu_result = $signed(dec.a) >>> dec.b[4:0];
      rv_isa_pkg::alu_or:       alu_result = dec.a | dec.b;
      rv_isa_pkg::alu_and:      alu_result = dec.a & dec.b;
      rv_isa_pkg::alu_lui_pass: alu_result = dec.b;
      default:                  alu_result = '0;
    endcase
  end

  mul_div_unit u_mul_div (
    .clk    (clk),
    .reset  (reset),
    .start  (start),
    .op     (dec.alu_op),
    .a      (dec.a),
    .b      (dec.b),
    .done   (done),
    .result (md_result)
  );

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= st_idle;
      exec_valid <= 1'b0;
    end else begin
      case (state)
        st_idle: begin
          if (take) begin
            exec_valid <= !is_m;
            if (is_m) begin
              state <= st_wait_mul_div;
            end
          end else if (accessor_ready) begin
            exec_valid <= 1'b0;
          end
        end
        st_wait_mul_div: begin
          if (done) begin
            state      <= st_hold;
            exec_valid <= 1'b1;
          end
        end
        default: begin
          if (accessor_ready) begin
            state      <= st_idle;
            exec_valid <= 1'b0;
          end
        end
      endcase
    end
  end

  // rd, mem op and store data are kept in exec while the unit runs
  always_ff @(posedge clk) begin
    if (take) begin
      exec.rd         <= dec.rd;
      exec.result     <= alu_result;
      exec.store_data <= dec.store_data;
      exec.mem_op     <= dec.mem_op;
    end else if (state == st_wait_mul_div && done) begin
      exec.result <= md_result;
    end
  end

  a_no_early_valid: assert property (@(posedge clk) disable iff (reset)
    state == st_wait_mul_div && !done |=> !exec_valid)
    else $error("executor: valid raised before the mul/div unit finished");

endmodule

/* hdl/accessor.sv */
`timescale 1ns/1ns

module accessor #(
  parameter int dmem_words = 256
) (
  input  var logic                  clk,
  input  var logic                  reset,
  input  var logic                  exec_valid,
  input  var pipe_pkg::executed_t   exec,
  output var logic                  wb_en,
  output var rv_isa_pkg::reg_addr_t wb_rd,
  output var rv_isa_pkg::word_t     wb_data
);
  localparam int idx_w = $clog2(dmem_words);

  rv_isa_pkg::word_t   mem [dmem_words];
  rv_isa_pkg::word_t   wdata, rdata, lane_data, result_q;
  logic [3:0]          mask;
  logic [idx_w-1:0]    idx;
  logic [1:0]          off_q;
  rv_isa_pkg::mem_op_t op_q;

  assign idx = exec.result[idx_w+1:2];

  always_comb begin
    case (exec.mem_op)
      rv_isa_pkg::mem_sb: begin
        wdata = {4{exec.store_data[7:0]}};
        mask  = 4'b0001 << exec.result[1:0];
      end
      rv_isa_pkg::mem_sh: begin
        wdata = {2{exec.store_data[15:0]}};
        mask  = exec.result[1] ? 4'b1100 : 4'b0011;
      end
      rv_isa_pkg::mem_sw: begin
        wdata = exec.store_data;
        mask  = 4'b1111;
      end
      default: begin
        wdata = exec.store_data;
        mask  = 4'b0000;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (exec_valid) begin
      for (int i = 0; i < 4; i++) begin
        if (mask[i]) begin
          mem[idx][8*i +: 8] <= wdata[8*i +: 8];
        end
      end
      rdata    <= mem[idx];
      op_q     <= exec.mem_op;
      off_q    <= exec.result[1:0];
      result_q <= exec.result;
      wb_rd    <= exec.rd;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_en <= 1'b0;
    end else begin
      wb_en <= exec_valid;
    end
  end

  assign lane_data = rdata >> {off_q, 3'b000};

  always_comb begin
    if (wb_rd == '0) begin
      wb_data = '0;
    end else begin
      case (op_q)
        rv_isa_pkg::mem_lb:  wb_data = {{24{lane_data[7]}}, lane_data[7:0]};
        rv_isa_pkg::mem_lbu: wb_data = {24'b0, lane_data[7:0]};
        rv_isa_pkg::mem_lh:  wb_data = {{16{lane_data[15]}}, lane_data[15:0]};
        rv_isa_pkg::mem_lhu: wb_data = {16'b0, lane_data[15:0]};
        rv_isa_pkg::mem_lw:  wb_data = rdata;
        default:             wb_data = result_q;
      endcase
    end
  end

  a_aligned: assert property (@(posedge clk) disable iff (reset)
    exec_valid |->
      !((exec.mem_op inside {rv_isa_pkg::mem_lh, rv_isa_pkg::mem_lhu, rv_isa_pkg::mem_sh}
         && exec.result[0]) ||
        (exec.mem_op inside {rv_isa_pkg::mem_lw, rv_isa_pkg::mem_sw}
         && exec.result[1:0] != 2'b00)))
    else $error("accessor: misaligned access at %h", exec.result);

endmodule

/* hdl/core_backend.sv */
`timescale 1ns/1ns

module core_backend #(
  parameter int dmem_words = 256
) (
  input  var logic                  clk,
  input  var logic                  reset,
  input  var logic                  instr_valid,
  input  var rv_isa_pkg::word_t     instr,
  output var logic                  instr_ready,
  output var logic                  retire_valid,
  output var rv_isa_pkg::reg_addr_t retire_rd,
  output var rv_isa_pkg::word_t     retire_data
);
  rv_isa_pkg::reg_addr_t rs1_addr, rs2_addr, wb_rd;
  rv_isa_pkg::word_t     rs1_data, rs2_data, wb_data;
  logic                  dec_valid, exec_ready, exec_valid, accessor_ready, wb_en;
  pipe_pkg::decoded_t    dec;
  pipe_pkg::executed_t   exec;

  // accessor never stalls
  assign accessor_ready = 1'b1;

  assign retire_valid = wb_en;
  assign retire_rd    = wb_rd;
  assign retire_data  = wb_data;

  register_file u_register_file (
    .clk      (clk),
    .reset    (reset),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .wb_en    (wb_en),
    .wb_rd    (wb_rd),
    .wb_data  (wb_data)
  );

  decoder u_decoder (
    .clk         (clk),
    .reset       (reset),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_ready (instr_ready),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .dec_valid   (dec_valid),
    .dec         (dec),
    .dec_ready   (exec_ready),
    .wb_en       (wb_en),
    .wb_rd       (wb_rd)
  );

  executor u_executor (
    .clk            (clk),
    .reset          (reset),
    .dec_valid      (dec_valid),
    .dec            (dec),
    .exec_ready     (exec_ready),
    .exec_valid     (exec_valid),
    .exec           (exec),
    .accessor_ready (accessor_ready)
  );

  accessor #(
    .dmem_words (dmem_words)
  ) u_accessor (
    .clk        (clk),
    .reset      (reset),
    .exec_valid (exec_valid),
    .exec       (exec),
    .wb_en      (wb_en),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data)
  );

endmodule

/* test/tb_core_backend.sv */
`timescale 1ns/1ns

module tb_core_backend;
  logic                  clk;
  logic                  reset;
  logic                  instr_valid;
  rv_isa_pkg::word_t     instr;
  logic                  instr_ready;
  logic                  retire_valid;
  rv_isa_pkg::reg_addr_t retire_rd;
  rv_isa_pkg::word_t     retire_data;

  rv_isa_pkg::word_t     sreg [32];
  logic [7:0]            smem [1024];
  rv_isa_pkg::reg_addr_t exp_rd_q [$];
  rv_isa_pkg::word_t     exp_data_q [$];
  rv_isa_pkg::reg_addr_t exp_rd;
  rv_isa_pkg::word_t     exp_data;
  logic                  exp_pending;
  rv_isa_pkg::word_t     seed;
  int                    errors, errors_seen, tests_ok, tests_bad, cycles, cycle_limit;

  core_backend #(.dmem_words(256)) uut (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .instr_ready  (instr_ready),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_data  (retire_data)
  );

  always #5 clk = ~clk;

  a_retire_expected: assert property (@(posedge clk) disable iff (reset)
    retire_valid |-> exp_pending)
    else begin
      errors++;
      $display("retire at %0t with no instruction outstanding", $time);
    end

  a_retire_rd: assert property (@(posedge clk) disable iff (reset)
    retire_valid && exp_pending |-> retire_rd == exp_rd)
    else begin
      errors++;
      $display("FAILED %0t retire_rd got %0d expected %0d", $time,
               $sampled(retire_rd), $sampled(exp_rd));
    end

  a_retire_data: assert property (@(posedge clk) disable iff (reset)
    retire_valid && exp_pending |-> retire_data == exp_data)
    else begin
      errors++;
      $display("FAILED %0t retire_data got %h expected %h", $time,
               $sampled(retire_data), $sampled(exp_data));
    end

  task automatic refresh_head();
    exp_pending = exp_rd_q.size() > 0;
    exp_rd      = exp_pending ? exp_rd_q[0] : '0;
    exp_data    = exp_pending ? exp_data_q[0] : '0;
  endtask

  always @(posedge clk) begin
    if (!reset && retire_valid && exp_rd_q.size() > 0) begin
      void'(exp_rd_q.pop_front());
      void'(exp_data_q.pop_front());
      refresh_head();
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > cycle_limit) begin
      $display("timeout after %0d cycles with %0d retires outstanding",
               cycles, exp_rd_q.size());
      $display("TB FAILED");
      $finish;
    end
  end

  function automatic rv_isa_pkg::word_t rand_word();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  function automatic rv_isa_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
                                                 input rv_isa_pkg::word_t a,
                                                 input rv_isa_pkg::word_t b);
    logic signed [31:0] sa;
    sa = a;
    case (f3)
      3'd0:    return alt ? a - b : a + b;
      3'd1:    return a << b[4:0];
      3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'd3:    return (a < b) ? 32'd1 : 32'd0;
      3'd4:    return a ^ b;
      3'd5:    return alt ? 32'(sa >>> b[4:0]) : a >> b[4:0];
      3'd6:    return a | b;
      default: return a & b;
    endcase
  endfunction

  function automatic rv_isa_pkg::word_t md_ref(input logic [2:0] f3,
                                                input rv_isa_pkg::word_t a,
                                                input rv_isa_pkg::word_t b);
    logic [63:0]        p;
    logic signed [31:0] q;
    logic               ovf;
    ovf = a == 32'h8000_0000 && b == 32'hffff_ffff;
    case (f3)
      3'd0: begin
        p = {32'b0, a} * {32'b0, b};
        return p[31:0];
      end
      3'd1: begin
        p = {{32{a[31]}}, a} * {{32{b[31]}}, b};
        return p[63:32];
      end
      3'd2: begin
        p = {{32{a[31]}}, a} * {32'b0, b};
        return p[63:32];
      end
      3'd3: begin
        p = {32'b0, a} * {32'b0, b};
        return p[63:32];
      end
      3'd4: begin
        if (b == 0) return 32'hffff_ffff;
        if (ovf) return a;
        q = $signed(a) / $signed(b);
        return q;
      end
      3'd5:    return (b == 0) ? 32'hffff_ffff : a / b;
      3'd6: begin
        if (b == 0) return a;
        if (ovf) return 32'd0;
        q = $signed(a) % $signed(b);
        return q;
      end
      default: return (b == 0) ? a : a % b;
    endcase
  endfunction

  // shadow of the pipeline, applied in issue order
  task automatic model(input rv_isa_pkg::word_t ins);
    rv_isa_pkg::word_t     a, b, res, addr, imm;
    rv_isa_pkg::reg_addr_t rd;
    logic [2:0]            f3;
    logic                  wr;
    a    = sreg[ins[19:15]];
    b    = sreg[ins[24:20]];
    rd   = ins[11:7];
    f3   = ins[14:12];
    imm  = {{20{ins[31]}}, ins[31:20]};
    wr   = 1'b1;
    res  = '0;
    case (ins[6:0])
      7'h37: res = {ins[31:12], 12'b0};
      7'h13: res = alu_ref(f3, f3 == 3'd5 && ins[30], a, imm);
      7'h33: res = ins[25] ? md_ref(f3, a, b) : alu_ref(f3, ins[30], a, b);
      7'h03: begin
        addr = a + imm;
        res  = {smem[addr[9:0] + 3], smem[addr[9:0] + 2],
                smem[addr[9:0] + 1], smem[addr[9:0]]};
        case (f3)
          3'd0:    res = {{24{res[7]}}, res[7:0]};
          3'd1:    res = {{16{res[15]}}, res[15:0]};
          3'd4:    res = {24'b0, res[7:0]};
          3'd5:    res = {16'b0, res[15:0]};
          default: ;
        endcase
      end
      7'h23: begin
        addr = a + {{20{ins[31]}}, ins[31:25], ins[11:7]};
        for (int i = 0; i < 4; i++) begin
          if (i < (1 << f3)) smem[addr[9:0] + i] = b[8*i +: 8];
        end
        wr = 1'b0;
      end
      default: wr = 1'b0;
    endcase
    if (!wr) rd = '0;
    if (rd != '0) sreg[rd] = res;
    else res = '0;
    exp_rd_q.push_back(rd);
    exp_data_q.push_back(res);
    refresh_head();
  endtask

  // called 1 ns after a rising edge, returns 1 ns after the transfer edge
  task automatic send(input rv_isa_pkg::word_t ins);
    instr_valid = 1'b1;
    instr       = ins;
    @(negedge clk);
    while (!instr_ready) @(negedge clk);
    model(ins);
    cycle_limit += 70;
    @(posedge clk);
    #1;
    instr_valid = 1'b0;
  endtask

  function automatic rv_isa_pkg::word_t enc_r(input logic [6:0] f7, input int rs2, rs1,
                                               input logic [2:0] f3, input int rd);
    return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'h33};
  endfunction

  function automatic rv_isa_pkg::word_t enc_i(input logic [11:0] imm, input int rs1,
                                               input logic [2:0] f3, input int rd,
                                               input logic [6:0] opc);
    return {imm, 5'(rs1), f3, 5'(rd), opc};
  endfunction

  function automatic rv_isa_pkg::word_t enc_s(input logic [11:0] imm, input int rs2, rs1,
                                               input logic [2:0] f3);
    return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], 7'h23};
  endfunction

  task automatic load_const(input int rd, input rv_isa_pkg::word_t v);
    rv_isa_pkg::word_t upper;
    upper = (v + 32'h800) >> 12;
    send({upper[19:0], 5'(rd), 7'h37});
    send(enc_i(v[11:0], rd, 3'd0, rd, 7'h13));
  endtask

  task automatic finish_test(input string name);
    @(negedge clk);
    while (exp_pending) @(negedge clk);
    @(posedge clk);
    #1;
    if (errors == errors_seen) tests_ok++;
    else tests_bad++;
    $display("test %s done, %0d errors", name, errors - errors_seen);
    errors_seen = errors;
  endtask

  task automatic run_mul_div(input int f3_lo);
    int pairs [4][2] = '{'{3, 4}, '{1, 2}, '{1, 5}, '{4, 2}};
    for (int p = 0; p < 4; p++) begin
      for (int f = f3_lo; f < f3_lo + 4; f++) begin
        send(enc_r(7'h01, pairs[p][1], pairs[p][0], 3'(f), 6 + f % 4));
      end
    end
  endtask

  initial begin
    rv_isa_pkg::word_t v;
    clk = 0;
    reset = 1;
    instr_valid = 0;
    instr = '0;
    seed = 32'd86;
    errors = 0;
    errors_seen = 0;
    tests_ok = 0;
    tests_bad = 0;
    cycles = 0;
    cycle_limit = 200;
    foreach (sreg[i]) sreg[i] = '0;
    refresh_head();
    repeat (5) @(posedge clk);
    #1;
    a_reset_ready: assert (instr_ready == 1'b0)
      else begin
        errors++;
        $display("FAILED %0t instr_ready got %b expected 0", $time, instr_ready);
      end
    a_reset_retire: assert (retire_valid == 1'b0)
      else begin
        errors++;
        $display("FAILED %0t retire_valid got %b expected 0", $time, retire_valid);
      end
    reset = 0;

    repeat (10) @(posedge clk);
    #1;
    finish_test("idle after reset");

    for (int r = 1; r <= 4; r++) begin
      v = rand_word();
      load_const(r, v);
    end
    for (int f = 0; f < 8; f++) begin
      for (int alt = 0; alt < 2; alt++) begin
        if (alt == 0 || f == 0 || f == 5) begin
          send(enc_r(alt ? 7'h20 : 7'h00, 1 + alt, 3 - alt, 3'(f), 5 + f % 4));
          v = rand_word();
          if (f == 1 || f == 5) v[11:5] = alt ? 7'h20 : 7'h00;
          if (alt == 0 || f == 5) send(enc_i(v[11:0], 4 - alt, 3'(f), 6, 7'h13));
        end
      end
    end
    finish_test("alu");

    load_const(1, 32'h8000_0000);
    load_const(2, 32'hffff_ffff);
    load_const(5, 32'd0);
    run_mul_div(0);
    finish_test("multiply");
    run_mul_div(4);
    finish_test("divide");

    load_const(10, 32'h100);
    for (int w = 0; w < 4; w++) begin
      v = rand_word();
      load_const(11, v);
      send(enc_s(12'(4 * w), 11, 10, 3'd2));
    end
    send(enc_s(12'd1, 3, 10, 3'd0));
    send(enc_s(12'd6, 4, 10, 3'd0));
    send(enc_s(12'd10, 2, 10, 3'd1));
    send(enc_s(12'd12, 3, 10, 3'd1));
    for (int o = 0; o < 16; o++) begin
      send(enc_i(12'(o), 10, 3'd0, 14, 7'h03));
      send(enc_i(12'(o), 10, 3'd4, 15, 7'h03));
      send(enc_i(12'(o & 14), 10, 3'd1, 16, 7'h03));
      send(enc_i(12'(o & 14), 10, 3'd5, 17, 7'h03));
      send(enc_i(12'(o & 12), 10, 3'd2, 18, 7'h03));
    end
    finish_test("load store");

    for (int k = 0; k < 3; k++) begin
      v = rand_word();
      load_const(3, v);
      v = rand_word();
      load_const(4, v);
      send(enc_r(7'h01, 4, 3, 3'd0, 6));
      send(enc_r(7'h00, 3, 6, 3'd0, 7));
      send(enc_r(7'h01, 4, 7, 3'd4, 8));
      send(enc_i(12'd5, 8, 3'd0, 9, 7'h13));
      send(enc_r(7'h01, 6, 9, 3'd3, 6));
      send(enc_r(7'h20, 9, 6, 3'd0, 7));
      send(enc_r(7'h01, 3, 7, 3'd6, 8));
      send(enc_s(12'd16, 8, 10, 3'd2));
      send(enc_i(12'd16, 10, 3'd2, 9, 7'h03));
      send(enc_r(7'h00, 7, 9, 3'd4, 6));
    end
    finish_test("dependent chains");

    $display("tests passed %0d failed %0d, %0d errors", tests_ok, tests_bad, errors);
    if (errors == 0 && tests_bad == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
common/rv_isa_pkg.sv
common/pipe_pkg.sv
hdl/register_file.sv
decoder/decoder.sv
executor/mul_div_unit.sv
executor/executor.sv
hdl/accessor.sv
hdl/core_backend.sv
test/tb_core_backend.sv

/* run_sim.sh */
#!/usr/bin/env bash
# compile and run the core_backend testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_core_backend \
  -f sources.f \
  -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
if [ $? -ne 0 ]; then
  cat sim.log
  echo "simulation exited with an error"
  exit 1
fi

cat sim.log
if grep -qx "TB PASSED" sim.log; then
  exit 0
fi
exit 1
